/* Makefile */
# Verilator build and run for the cpuCore testbench
# A failing run exits nonzero through $fatal

TOP ?= cpuCoreTb
FILELIST ?= cpuCore.f
BUILD_DIR ?= obj_dir
VERILATOR ?= verilator
FLAGS ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* cpuCore.f */
+incdir+include
design/cpuPkg.sv
design/fetchUnit.sv
design/decoder.sv
design/regFile.sv
design/alu.sv
design/memAccess.sv
design/cpuCore.sv
verification/cpuCoreTb.sv

/* design/alu.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module alu (
	input logic clk,
	input logic rstN,
	input logic [`OPC_W-1:0] opcode,
	input cpuPkg::wordT dstVal, // rd operand
	input cpuPkg::wordT srcVal, // rs operand
	output cpuPkg::wordT aluOut,
	output logic cFlag,
	output logic zFlag
);

	logic [`WORD_W:0] sum; // Extra bit is the carry
	logic isAdd;

	assign sum = {1'b0, dstVal} + {1'b0, srcVal};
	assign isAdd = (opcode == `ADD_OP);

	// Result
	always_comb begin
		if (opcode == `MV_OP) begin
			aluOut = srcVal; // Plain move
		end else begin
			aluOut = sum[`WORD_W-1:0];
		end
	end

	// Flags change only on ADD and hold otherwise
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			cFlag <= 1'b0;
			zFlag <= 1'b0;
		end else if (isAdd) begin
			cFlag <= sum[`WORD_W]; // Carry out
			zFlag <= (sum[`WORD_W-1:0] == '0); // Truncated sum is zero
		end
	end

endmodule

/* design/cpuCore.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpuCore (
	input logic clk,
	input logic rstN,
	output cpuPkg::wordT iAddr, // Instruction memory address
	input cpuPkg::wordT iData, // Answers in the same cycle
	output cpuPkg::wordT dAddr,
	output cpuPkg::wordT dWData,
	output logic dWE, // Store strobe
	input cpuPkg::wordT dRData
);

	import cpuPkg::*;

	// Decoded fields and controls
	logic [`OPC_W-1:0] opcode;
	regIdxT regDst;
	regIdxT regSrc;
	pcSelT nextPCSel;
	wordT instrData;
	logic regFileWE;
	logic immData;
	logic regDataInSource;
	logic memWE;
	logic memAddrSelDst;
	logic memAddrSelSrc;

	// Datapath
	wordT dstVal;
	wordT srcVal;
	wordT aluOut;
	wordT wbData;
	logic cFlag;
	logic zFlag;

	fetchUnit uFetch (
		.clk(clk),
		.rstN(rstN),
		.nextPCSel(nextPCSel),
		.instrData(instrData),
		.srcVal(srcVal),
		.pc(iAddr) // PC is the fetch address
	);

	decoder uDecoder (
		.instruction(iData),
		.opcode(opcode),
		.cFlag(cFlag),
		.zFlag(zFlag),
		.nextPCSel(nextPCSel),
		.regDataInSource(regDataInSource),
		.immData(immData),
		.regDst(regDst),
		.regFileWE(regFileWE),
		.regSrc(regSrc),
		.memWE(memWE),
		.memAddrSelDst(memAddrSelDst),
		.memAddrSelSrc(memAddrSelSrc),
		.instrData(instrData)
	);

	// rd is both the first read port and the write target
	regFile uRegFile (
		.clk(clk),
		.rstN(rstN),
		.rdAddrA(regDst),
		.rdAddrB(regSrc),
		.we(regFileWE),
		.wrAddr(regDst),
		.wrData(wbData),
		.rdDataA(dstVal),
		.rdDataB(srcVal)
	);

	alu uAlu (
		.clk(clk),
		.rstN(rstN),
		.opcode(opcode),
		.dstVal(dstVal),
		.srcVal(srcVal),
		.aluOut(aluOut),
		.cFlag(cFlag),
		.zFlag(zFlag)
	);

	memAccess uMem (
		.memAddrSelDst(memAddrSelDst),
		.memAddrSelSrc(memAddrSelSrc),
		.memWE(memWE),
		.immData(immData),
		.regDataInSource(regDataInSource),
		.dstVal(dstVal),
		.srcVal(srcVal),
		.aluOut(aluOut),
		.instrData(instrData),
		.dRData(dRData),
		.dAddr(dAddr),
		.dWData(dWData),
		.dWE(dWE),
		.wbData(wbData)
	);

endmodule

/* design/cpuPkg.sv */
`include "cpu_consts.svh"

package cpuPkg;

	// One word for instructions, registers, addresses and memory data
	typedef logic [`WORD_W-1:0] wordT;

	// Register file index
	typedef logic [$clog2(`REG_COUNT)-1:0] regIdxT;

	// Next program counter source
	typedef enum logic [1:0] {
		pcSeq = 2'd0, // pc + 1
		pcImm = 2'd1, // Zero-extended payload
		pcReg = 2'd2  // Value of rs
	} pcSelT;

endpackage

/* design/decoder.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decoder (
	input cpuPkg::wordT instruction,
	output logic [`OPC_W-1:0] opcode, // Also consumed by alu

	input logic cFlag, // Branch condition inputs
	input logic zFlag,
	output cpuPkg::pcSelT nextPCSel, // Next PC source

	output logic regDataInSource, // Write back from data memory
	output logic immData, // Write back from instrData
	output cpuPkg::regIdxT regDst,
	output logic regFileWE,
	output cpuPkg::regIdxT regSrc,

	output logic memWE,
	output logic memAddrSelDst, // dAddr from rd
	output logic memAddrSelSrc, // dAddr from rs
	output cpuPkg::wordT instrData // Zero-extended payload
);

	import cpuPkg::*;

	logic [`PAYLOAD_W-1:0] payload;
	logic brFlagSel;
	logic brFlag;
	logic brTaken;

	// Fixed field positions, so register indices come out for every op
	// Unused fields are harmless since the controls stay inactive
	assign opcode = instruction[`OPC_MSB:`OPC_LSB];
	assign regDst = instruction[`RD_MSB:`RD_LSB];
	assign regSrc = instruction[`RS_MSB:`RS_LSB];
	assign payload = instruction[`PAYLOAD_W-1:0];

	assign brFlagSel = instruction[`BR_SEL_BIT]; // 0 carry, 1 zero
	assign brFlag = instruction[`BR_VAL_BIT];

	// Selected flag must match the wanted value
	assign brTaken = brFlagSel ? (brFlag == zFlag) : (brFlag == cFlag);

	always_comb begin
		// Everything inactive unless the opcode says otherwise
		nextPCSel = pcSeq;
		regDataInSource = 1'b0;
		immData = 1'b0;
		regFileWE = 1'b0;
		memWE = 1'b0;
		memAddrSelDst = 1'b0;
		memAddrSelSrc = 1'b0;
		instrData = '0;

		case (opcode)
			`ADD_OP: begin
				regFileWE = 1'b1; // Sum goes back to rd
			end

			`LDI_OP: begin
				immData = 1'b1; // Write back the payload
				regFileWE = 1'b1;
				instrData = {{(`WORD_W-`PAYLOAD_W){1'b0}}, payload};
			end

			`LDR_OP: begin
				memAddrSelSrc = 1'b1; // Address held in rs
				regDataInSource = 1'b1; // Load data to rd
				regFileWE = 1'b1;
			end

			`MV_OP: begin
				regFileWE = 1'b1; // alu passes rs through
			end

			`ST_OP: begin
				memAddrSelDst = 1'b1; // Address held in rd
				memWE = 1'b1;
			end

			`BRI_OP: begin
				if (brTaken) begin
					nextPCSel = pcImm;
					instrData = {{(`WORD_W-`PAYLOAD_W){1'b0}}, payload}; // Target address
				end
			end

			`BRR_OP: begin
				if (brTaken) begin
					nextPCSel = pcReg; // Target from rs
				end
			end

			default: begin
				// Opcodes 7 to 15 act as no-ops
			end
		endcase
	end

endmodule

/* design/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit (
	input logic clk,
	input logic rstN,
	input cpuPkg::pcSelT nextPCSel, // From decoder
	input cpuPkg::wordT instrData, // Branch target for BRI
	input cpuPkg::wordT srcVal, // Branch target for BRR
	output cpuPkg::wordT pc // Drives iAddr
);

	import cpuPkg::*;

	wordT pcInc;
	wordT pcNext;

	assign pcInc = pc + 1'b1; // Sequential address

	// Pick the address of the next instruction
	always_comb begin
		case (nextPCSel)
			pcImm: pcNext = instrData; // Already zero-extended
			pcReg: pcNext = srcVal;
			default: pcNext = pcInc; // pcSeq and unused code
		endcase
	end

	// Program counter
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0; // Fetch starts at word 0
		end else begin
			pc <= pcNext;
		end
	end

endmodule

/* design/memAccess.sv */
`timescale 1ns/1ps

module memAccess (
	input logic memAddrSelDst,
	input logic memAddrSelSrc,
	input logic memWE,
	input logic immData,
	input logic regDataInSource,
	input cpuPkg::wordT dstVal,
	input cpuPkg::wordT srcVal,
	input cpuPkg::wordT aluOut,
	input cpuPkg::wordT instrData,
	input cpuPkg::wordT dRData, // Same-cycle read data
	output cpuPkg::wordT dAddr,
	output cpuPkg::wordT dWData,
	output logic dWE,
	output cpuPkg::wordT wbData // To register file write port
);

	// Data address, rd for stores and rs for loads
	assign dAddr = memAddrSelDst ? dstVal :
		memAddrSelSrc ? srcVal : '0;

	assign dWData = srcVal; // ST always writes rs
	assign dWE = memWE;

	// Write back priority: immediate, then memory, then alu
	always_comb begin
		if (immData) begin
			wbData = instrData;
		end else if (regDataInSource) begin
			wbData = dRData; // LDR
		end else begin
			wbData = aluOut; // ADD and MV
		end
	end

endmodule

/* design/regFile.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module regFile (
	input logic clk,
	input logic rstN,
	input cpuPkg::regIdxT rdAddrA, // rd in this core
	input cpuPkg::regIdxT rdAddrB, // rs
	input logic we,
	input cpuPkg::regIdxT wrAddr, // Always rd
	input cpuPkg::wordT wrData,
	output cpuPkg::wordT rdDataA,
	output cpuPkg::wordT rdDataB
);

	import cpuPkg::*;

	wordT regs [`REG_COUNT];

	// Combinational read ports
	// Old value is seen in the same cycle as a write to it
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

	// Single write port, lands at the edge
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0; // Architectural state starts at zero
			end
		end else if (we) begin
			regs[wrAddr] <= wrData;
		end
	end

endmodule

/* include/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath sizes
`define WORD_W 16 // Instruction and data width
`define REG_COUNT 16 // Architectural registers
`define OPC_W 4 // Opcode field width

// Opcodes in instruction[15:12]
`define ADD_OP 4'd0 // rd = rd + rs, flags updated
`define LDI_OP 4'd1 // rd = zero-extended payload
`define LDR_OP 4'd2 // rd = mem[rs]
`define MV_OP 4'd3 // rd = rs
`define ST_OP 4'd4 // mem[rd] = rs
`define BRI_OP 4'd5 // Conditional jump to payload
`define BRR_OP 4'd6 // Conditional jump to rs

// Branch condition field
// Bit 9 picks the flag, 0 for carry and 1 for zero
`define BR_SEL_BIT 9
`define BR_VAL_BIT 8 // Flag value that takes the branch

// Field positions
`define OPC_MSB 15
`define OPC_LSB 12
`define RD_MSB 11
`define RD_LSB 8
`define RS_MSB 7
`define RS_LSB 4
`define PAYLOAD_W 8 // Low byte holds immediate or address

`endif

/* verification/cpuCoreTb.sv */
`timescale 1ns/1ps

module cpuCoreTb;

	logic clk;
	logic rstN;
	logic [15:0] iAddr;
	logic [15:0] iData;
	logic [15:0] dAddr;
	logic [15:0] dWData;
	logic dWE;
	logic [15:0] dRData;

	// Memory models indexed by the low address byte
	logic [15:0] instrMem [256];
	logic [15:0] dataMem [256];

	// Golden records tagged with their test index
	string testNames[$];
	int progTest[$];
	logic [15:0] progAddr[$];
	logic [15:0] progWord[$];
	int initTest[$];
	logic [15:0] initAddr[$];
	logic [15:0] initData[$];
	int storeTest[$];
	logic [15:0] storeAddr[$];
	logic [15:0] storeData[$];

	int cycleCount = 0;
	int cycleLimit = 0; // Set once the golden file is read

	cpuCore DUT (
		.clk(clk),
		.rstN(rstN),
		.iAddr(iAddr),
		.iData(iData),
		.dAddr(dAddr),
		.dWData(dWData),
		.dWE(dWE),
		.dRData(dRData)
	);

	assign iData = instrMem[iAddr[7:0]]; // Same-cycle fetch
	assign dRData = dataMem[dAddr[7:0]];

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "Run aborted");
	endtask

	task automatic checkValue(input string label, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected) begin
			$display("Fail %s expected %h actual %h", label, expected, actual);
			$display("TESTBENCH FAILED");
			$fatal(1, "Value mismatch");
		end
	endtask

	// Guard against a program that never reaches its stores
	always @(posedge clk) begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			abortRun($sformatf("Timeout, the tests did not finish in %0d cycles",
				cycleLimit));
		end
	end

	task automatic readGolden();
		int fd;
		int code;
		int cur;
		string line;
		string name;
		byte kind;
		logic [15:0] a;
		logic [15:0] b;
		cur = -1;
		fd = $fopen("verification/cpuGolden.txt", "r");
		if (fd == 0) begin
			abortRun("Cannot open the golden file verification/cpuGolden.txt");
		end
		while ($fgets(line, fd) > 0) begin
			kind = line.getc(0); // Comments and blank lines fall through
			if (kind == "T") begin
				code = $sscanf(line, "T %s", name);
				testNames.push_back(name);
				cur++;
			end else if (kind == "P" || kind == "M" || kind == "S") begin
				code = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
				if (code != 2) begin
					abortRun({"Malformed golden line ", line});
				end
				if (kind == "P") begin
					progTest.push_back(cur);
					progAddr.push_back(a);
					progWord.push_back(b);
				end else if (kind == "M") begin
					initTest.push_back(cur);
					initAddr.push_back(a);
					initData.push_back(b);
				end else begin
					storeTest.push_back(cur); // Expected store, in order
					storeAddr.push_back(a);
					storeData.push_back(b);
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic loadTest(input int t);
		for (int i = 0; i < 256; i++) begin
			instrMem[i] = {8'hF0, i[7:0]}; // Opcode 15 no-op
			dataMem[i] = {~i[7:0], i[7:0]};
		end
		foreach (progTest[k]) begin
			if (progTest[k] == t) instrMem[progAddr[k][7:0]] = progWord[k];
		end
		foreach (initTest[k]) begin
			if (initTest[k] == t) dataMem[initAddr[k][7:0]] = initData[k];
		end
	endtask

	task automatic runTest(input int t);
		string name;
		logic [15:0] expAddr[$];
		logic [15:0] expData[$];
		logic [15:0] wrAddr;
		logic [15:0] wrData;
		logic pending;
		int seen;
		int tail;
		int cyc;
		name = testNames[t];
		foreach (storeTest[k]) begin
			if (storeTest[k] == t) begin
				expAddr.push_back(storeAddr[k]);
				expData.push_back(storeData[k]);
			end
		end
		rstN = 1'b0;
		loadTest(t);
		repeat (5) begin
			@(posedge clk);
			checkValue($sformatf("%s reset iAddr", name), 16'h0000, iAddr);
			#1;
		end
		rstN = 1'b1;
		seen = 0;
		tail = 0;
		cyc = 0;
		while (tail < 10) begin
			@(posedge clk);
			pending = 1'b0;
			if (seen == expAddr.size()) begin
				tail++; // Cycles after the last expected store
			end
			if (cyc == 0) begin
				checkValue($sformatf("%s first iAddr", name), 16'h0000, iAddr);
			end
			if (dWE) begin
				if (seen >= expAddr.size()) begin
					abortRun($sformatf("Test %s made an extra store to address %h",
						name, dAddr));
				end
				checkValue($sformatf("%s store %0d address", name, seen),
					expAddr[seen], dAddr);
				checkValue($sformatf("%s store %0d data", name, seen),
					expData[seen], dWData);
				wrAddr = dAddr;
				wrData = dWData;
				pending = 1'b1;
				seen++;
			end
			#1;
			if (pending) dataMem[wrAddr[7:0]] = wrData; // Memory write after the edge
			cyc++;
		end
	endtask

	initial begin
		rstN = 1'b0;
		readGolden();
		cycleLimit = 8 * progTest.size() + 100;
		if (testNames.size() == 0) begin
			abortRun("The golden file holds no tests");
		end
		for (int t = 0; t < testNames.size(); t++) begin
			runTest(t);
		end
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

/* verification/cpuGolden.txt */
# T name, P addr word (program), M addr value (data preload), S addr data (expected store)
# All numbers in hex, stores listed in the order they occur
T immediate_path
P 00 1105
P 01 12A7
P 02 4120
P 03 5003
P 04 5104
S 0005 00A7
T add_flags
M 10 FFFF
P 00 1210
P 01 2120
P 02 1301
P 03 1420
P 04 0130
P 05 5307
P 06 4430
P 07 4410
P 08 0330
P 09 500B
P 0A 4430
P 0B 4230
P 0C 500C
P 0D 510D
S 0020 0000
S 0010 0002
T load_move
M 30 BEEF
P 00 1530
P 01 2650
P 02 3760
P 03 1831
P 04 4870
P 05 5005
P 06 5106
S 0031 BEEF
T branches
P 00 1A08
P 01 1B40
P 02 60A0
P 03 4BB0
P 08 5110
P 09 4BA0
P 0A 5310
P 0B 4AB0
P 0C 500C
P 0D 510D
S 0040 0008
S 0008 0040
T reset_state
P 00 4000
P 01 1C7F
P 02 4CC0
P 03 5003
P 04 5104
S 0000 0000
S 007F 007F
